//--- src.f
+incdir+bench
hdl/ks10_bus_pkg.sv
hdl/ks10_bus_if.sv
hdl/bus_arb.sv
hdl/mem_ctrl.sv
hdl/ks10_bus.sv
bench/ks10_bus_tb.sv

//--- bench/ks10_bus_ref.svh
// testbench reference model: grant priority rule, shadow memory and expected read data

`ifndef KS10_BUS_REF_SVH
`define KS10_BUS_REF_SVH

//////////////////////////////////////////////////
// grant model
//////////////////////////////////////////////////

// owner after the next edge, given the owner now and the sampled lines
// a new grant only starts from an idle bus and never under power fail
// a held grant ends when its owner drops request, whoever else asks
function automatic ks10_bus_pkg::ks10_master_t next_owner
  (
   input ks10_bus_pkg::ks10_master_t cur,
   input logic                       con_r,
   input logic                       uba_r,
   input logic                       cpu_r,
   input logic                       pf
   );
   ks10_bus_pkg::ks10_master_t nxt;
   logic                       owner_r;
   nxt = cur;
   // request line of whoever holds the bus now
   owner_r = (cur == ks10_bus_pkg::MASTER_CON) ? con_r :
             (cur == ks10_bus_pkg::MASTER_UBA) ? uba_r : cpu_r;
   if (cur == ks10_bus_pkg::MASTER_NONE)
   begin
      // console first, then unibus adapter, then cpu
      if (pf)
         nxt = ks10_bus_pkg::MASTER_NONE;
      else if (con_r)
         nxt = ks10_bus_pkg::MASTER_CON;
      else if (uba_r)
         nxt = ks10_bus_pkg::MASTER_UBA;
      else if (cpu_r)
         nxt = ks10_bus_pkg::MASTER_CPU;
   end
   else if (!owner_r)
      nxt = ks10_bus_pkg::MASTER_NONE;
   return nxt;
endfunction

//////////////////////////////////////////////////
// shadow memory
//////////////////////////////////////////////////

// what the memory should hold after every write so far
ks10_bus_pkg::ks10_word_t shadow_mem [0:MEM_WORDS-1];

// physical address folded into the word array, modulo its size
function automatic int unsigned shadow_index(input logic [0:21] paddr);
   return paddr % MEM_WORDS;
endfunction

task automatic shadow_write(input logic [0:21] paddr, input ks10_bus_pkg::ks10_word_t word);
   shadow_mem[shadow_index(paddr)] = word;
endtask

// word a read of this address must return
function automatic ks10_bus_pkg::ks10_word_t expected_read(input logic [0:21] paddr);
   return shadow_mem[shadow_index(paddr)];
endfunction

`endif

//--- bench/ks10_bus_tb.sv
// testbench for ks10_bus with clock, reset, master stimulus, compare tasks, checker and timeout

`timescale 1ns/10ps

module ks10_bus_tb;

   localparam int MEM_WORDS      = 1024;
   localparam int N_RAND         = 16;
   // random writes and reads plus the directed tenures
   localparam int NUM_TRANS      = 2 * N_RAND + 10;
   localparam int TIMEOUT_CYCLES = NUM_TRANS * 12 + 200;

   logic                     clk;
   logic                     rst;
   logic                     pwr_fail;

   // master lines indexed by the master enum value (1 con, 2 uba, 3 cpu)
   logic                     req   [1:3];
   logic                     acyc  [1:3];
   logic                     dcyc  [1:3];
   logic                     iocyc [1:3];
   ks10_bus_pkg::ks10_word_t mdata [1:3];

   logic                     con_grant;
   logic                     uba_grant;
   logic                     cpu_grant;
   logic                     arb_addr_cycle;
   logic                     arb_data_cycle;
   logic                     arb_io_cycle;
   logic                     arb_mem_busy;
   ks10_bus_pkg::ks10_word_t arb_data;

   // words due on arb_data_cycle with the oldest first
   ks10_bus_pkg::ks10_word_t   expect_q [$];
   ks10_bus_pkg::ks10_master_t exp_owner   = ks10_bus_pkg::MASTER_NONE;
   int unsigned                cycle_count = 0;
   logic [0:21]                addr_list [0:N_RAND-1];

   `include "ks10_bus_ref.svh"

   ks10_bus #(.MEM_WORDS (MEM_WORDS)) dut_i
     (
      .clk            (clk),
      .rst            (rst),
      .pwr_fail       (pwr_fail),
      .con_request    (req[1]),
      .con_addr_cycle (acyc[1]),
      .con_data_cycle (dcyc[1]),
      .con_io_cycle   (iocyc[1]),
      .con_data       (mdata[1]),
      .con_grant      (con_grant),
      .uba_request    (req[2]),
      .uba_addr_cycle (acyc[2]),
      .uba_data_cycle (dcyc[2]),
      .uba_io_cycle   (iocyc[2]),
      .uba_data       (mdata[2]),
      .uba_grant      (uba_grant),
      .cpu_request    (req[3]),
      .cpu_addr_cycle (acyc[3]),
      .cpu_data_cycle (dcyc[3]),
      .cpu_io_cycle   (iocyc[3]),
      .cpu_data       (mdata[3]),
      .cpu_grant      (cpu_grant),
      .arb_addr_cycle (arb_addr_cycle),
      .arb_data_cycle (arb_data_cycle),
      .arb_io_cycle   (arb_io_cycle),
      .arb_mem_busy   (arb_mem_busy),
      .arb_data       (arb_data)
      );

   // 4 ns clock
   initial
   begin
      clk = 1'b0;
      forever
         #2 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // reporting and compare tasks
   //////////////////////////////////////////////////

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped");
   endtask

   task automatic report_error(input string msg);
      fail_run($sformatf("[ERROR] %0t: %s", $time, msg));
   endtask

   task automatic check_grant(input ks10_bus_pkg::ks10_master_t got,
                              input ks10_bus_pkg::ks10_master_t exp, input string what);
      if (got !== exp)
         report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
   endtask

   task automatic check_word(input ks10_bus_pkg::ks10_word_t got,
                             input ks10_bus_pkg::ks10_word_t exp, input string what);
      if (got !== exp)
         report_error($sformatf("%s is %09h, expected %09h", what, got, exp));
   endtask

   task automatic check_level(input logic got, input logic exp, input string what);
      if (got !== exp)
         report_error($sformatf("%s is %b, expected %b", what, got, exp));
   endtask

   // grant outputs read back as an owner
   function automatic ks10_bus_pkg::ks10_master_t current_owner();
      if (con_grant)
         return ks10_bus_pkg::MASTER_CON;
      if (uba_grant)
         return ks10_bus_pkg::MASTER_UBA;
      if (cpu_grant)
         return ks10_bus_pkg::MASTER_CPU;
      return ks10_bus_pkg::MASTER_NONE;
   endfunction

   // address word with the read and write flags and a physical address
   function automatic ks10_bus_pkg::ks10_word_t addr_word(input logic rd, input logic wr,
                                                          input logic [0:21] paddr);
      ks10_bus_pkg::ks10_addr_word_t w;
      w.data                                = '0;
      w.addr.flags[ks10_bus_pkg::FLAG_READ]  = rd;
      w.addr.flags[ks10_bus_pkg::FLAG_WRITE] = wr;
      w.addr.paddr                          = paddr;
      return w.data;
   endfunction

   //////////////////////////////////////////////////
   // master stimulus entered on a falling edge
   //////////////////////////////////////////////////

   task automatic acquire(input ks10_bus_pkg::ks10_master_t m);
      req[m] = 1'b1;
      @(negedge clk);
      while (current_owner() != m)
         @(negedge clk);
   endtask

   task automatic release_bus(input ks10_bus_pkg::ks10_master_t m);
      req[m] = 1'b0;
      @(negedge clk);
   endtask

   // write address and then the data cycle on the next clock
   task automatic mem_write(input ks10_bus_pkg::ks10_master_t m, input logic [0:21] paddr,
                            input ks10_bus_pkg::ks10_word_t word);
      ks10_bus_pkg::ks10_word_t aw;
      aw       = addr_word(1'b0, 1'b1, paddr);
      acyc[m]  = 1'b1;
      mdata[m] = aw;
      @(negedge clk);
      // address shows up one register stage later
      check_level(arb_addr_cycle, 1'b1, "arb_addr_cycle on write");
      check_word(arb_data, aw, "relayed write address");
      acyc[m]  = 1'b0;
      dcyc[m]  = 1'b1;
      mdata[m] = word;
      // the relayed write data is a data cycle as well
      expect_q.push_back(word);
      shadow_write(paddr, word);
      @(negedge clk);
      dcyc[m] = 1'b0;
   endtask

   task automatic mem_read(input ks10_bus_pkg::ks10_master_t m, input logic [0:21] paddr);
      ks10_bus_pkg::ks10_word_t aw;
      ks10_bus_pkg::ks10_word_t exp_word;
      aw       = addr_word(1'b1, 1'b0, paddr);
      exp_word = expected_read(paddr);
      // no new address cycle while the memory is busy
      check_level(arb_mem_busy, 1'b0, "arb_mem_busy before read");
      acyc[m]  = 1'b1;
      mdata[m] = aw;
      expect_q.push_back(exp_word);
      @(negedge clk);
      acyc[m] = 1'b0;
      check_level(arb_addr_cycle, 1'b1, "arb_addr_cycle on read");
      check_word(arb_data, aw, "relayed read address");
      // two busy cycles before the word comes back
      repeat (2)
      begin
         @(negedge clk);
         check_level(arb_mem_busy, 1'b1, "arb_mem_busy during read");
         check_level(arb_data_cycle, 1'b0, "arb_data_cycle before read data");
      end
      @(negedge clk);
      check_level(arb_data_cycle, 1'b1, "arb_data_cycle three cycles after read address");
      check_word(arb_data, exp_word, "read data");
      check_level(arb_mem_busy, 1'b0, "arb_mem_busy after read data");
   endtask

   // io address cycle that is relayed but never answered
   task automatic io_access(input ks10_bus_pkg::ks10_master_t m,
                            input ks10_bus_pkg::ks10_word_t word);
      acyc[m]  = 1'b1;
      iocyc[m] = 1'b1;
      mdata[m] = word;
      @(negedge clk);
      acyc[m]  = 1'b0;
      iocyc[m] = 1'b0;
      check_level(arb_addr_cycle, 1'b1, "arb_addr_cycle on io");
      check_level(arb_io_cycle, 1'b1, "arb_io_cycle on io");
      check_word(arb_data, word, "relayed io word");
      repeat (5)
      begin
         @(negedge clk);
         check_level(arb_data_cycle, 1'b0, "arb_data_cycle after io cycle");
         check_level(arb_mem_busy, 1'b0, "arb_mem_busy after io cycle");
      end
   endtask

   // strobes from a master without the grant as a memory read and then an io cycle
   task automatic drive_foreign(input ks10_bus_pkg::ks10_master_t m);
      // plain read address first so a leak would also start the memory
      acyc[m]  = 1'b1;
      dcyc[m]  = 1'b1;
      mdata[m] = addr_word(1'b1, 1'b0, 22'h0);
      @(negedge clk);
      check_level(arb_addr_cycle, 1'b0, "arb_addr_cycle from foreign master");
      check_level(arb_data_cycle, 1'b0, "arb_data_cycle from foreign master");
      dcyc[m]  = 1'b0;
      iocyc[m] = 1'b1;
      @(negedge clk);
      acyc[m]  = 1'b0;
      iocyc[m] = 1'b0;
      check_level(arb_addr_cycle, 1'b0, "arb_addr_cycle from foreign master");
      check_level(arb_io_cycle, 1'b0, "arb_io_cycle from foreign master");
      // a leaked read address would have raised busy by now
      check_level(arb_mem_busy, 1'b0, "arb_mem_busy after foreign strobes");
   endtask

   //////////////////////////////////////////////////
   // model, checker and timeout
   //////////////////////////////////////////////////

   // expected owner follows the sampled requests edge by edge
   always @(posedge clk or posedge rst)
   begin
      if (rst)
         exp_owner = ks10_bus_pkg::MASTER_NONE;
      else
         exp_owner = next_owner(exp_owner, req[1], req[2], req[3], pwr_fail);
   end

   // outputs are settled at the falling edge
   always @(negedge clk)
   begin : compare_proc
      ks10_bus_pkg::ks10_word_t exp_word;
      if (!rst)
      begin
         if (int'(con_grant) + int'(uba_grant) + int'(cpu_grant) > 1)
            report_error("more than one master holds a grant");
         check_grant(current_owner(), exp_owner, "bus owner");
         if (arb_data_cycle)
         begin
            if (expect_q.size() == 0)
               report_error("data cycle on the backplane with no word expected");
            else
            begin
               exp_word = expect_q.pop_front();
               check_word(arb_data, exp_word, "arb_data on data cycle");
            end
         end
      end
   end

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES)
         fail_run($sformatf("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES));
   end

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial
   begin : stimulus
      int                         i;
      ks10_bus_pkg::ks10_master_t m;
      logic [0:21]                raddr;
      ks10_bus_pkg::ks10_word_t   wdata;
      void'($urandom(32'h6e0dc375));
      rst      = 1'b1;
      pwr_fail = 1'b0;
      for (i = 1; i <= 3; i++)
      begin
         req[i]   = 1'b0;
         acyc[i]  = 1'b0;
         dcyc[i]  = 1'b0;
         iocyc[i] = 1'b0;
         mdata[i] = '0;
      end
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // quiet bus until somebody asks
      repeat (4)
      begin
         @(negedge clk);
         check_grant(current_owner(), ks10_bus_pkg::MASTER_NONE, "owner after reset");
         check_level(arb_addr_cycle, 1'b0, "arb_addr_cycle after reset");
         check_level(arb_data_cycle, 1'b0, "arb_data_cycle after reset");
         check_level(arb_io_cycle, 1'b0, "arb_io_cycle after reset");
         check_level(arb_mem_busy, 1'b0, "arb_mem_busy after reset");
      end

      // all three at once so the console wins, with one idle cycle per handover
      req[1] = 1'b1;
      req[2] = 1'b1;
      req[3] = 1'b1;
      @(negedge clk);
      check_grant(current_owner(), ks10_bus_pkg::MASTER_CON, "owner with all requesting");
      repeat (2) @(negedge clk);
      req[1] = 1'b0;
      @(negedge clk);
      check_grant(current_owner(), ks10_bus_pkg::MASTER_NONE, "owner after con release");
      @(negedge clk);
      check_grant(current_owner(), ks10_bus_pkg::MASTER_UBA, "owner after idle cycle");
      req[2] = 1'b0;
      @(negedge clk);
      check_grant(current_owner(), ks10_bus_pkg::MASTER_NONE, "owner after uba release");
      @(negedge clk);
      check_grant(current_owner(), ks10_bus_pkg::MASTER_CPU, "owner after idle cycle");
      // console asks while cpu holds the bus
      req[1] = 1'b1;
      repeat (3)
      begin
         @(negedge clk);
         check_grant(current_owner(), ks10_bus_pkg::MASTER_CPU, "held cpu grant");
      end
      req[3] = 1'b0;
      @(negedge clk);
      check_grant(current_owner(), ks10_bus_pkg::MASTER_NONE, "owner after cpu release");
      @(negedge clk);
      check_grant(current_owner(), ks10_bus_pkg::MASTER_CON, "owner after idle cycle");
      release_bus(ks10_bus_pkg::MASTER_CON);

      // relay of an io cycle and then strobes from the other two masters
      acquire(ks10_bus_pkg::MASTER_CPU);
      io_access(ks10_bus_pkg::MASTER_CPU, addr_word(1'b1, 1'b0, 22'($urandom)));
      drive_foreign(ks10_bus_pkg::MASTER_CON);
      drive_foreign(ks10_bus_pkg::MASTER_UBA);
      release_bus(ks10_bus_pkg::MASTER_CPU);

      // random writes with the masters taking turns
      for (i = 0; i < N_RAND; i++)
      begin
         addr_list[i] = 22'($urandom);
         wdata        = {4'($urandom), 32'($urandom)};
         m            = ks10_bus_pkg::ks10_master_t'(2'(i % 3 + 1));
         acquire(m);
         mem_write(m, addr_list[i], wdata);
         release_bus(m);
      end

      // read back with some addresses aliased one or two memory sizes up
      for (i = 0; i < N_RAND; i++)
      begin
         raddr = addr_list[i] + 22'(MEM_WORDS * (i % 3));
         m     = ks10_bus_pkg::ks10_master_t'(2'((i + 1) % 3 + 1));
         acquire(m);
         mem_read(m, raddr);
         release_bus(m);
      end

      // power fail lets the console finish but holds off the adapter
      acquire(ks10_bus_pkg::MASTER_CON);
      pwr_fail = 1'b1;
      req[2]   = 1'b1;
      mem_read(ks10_bus_pkg::MASTER_CON, addr_list[0]);
      req[1] = 1'b0;
      repeat (4)
      begin
         @(negedge clk);
         check_grant(current_owner(), ks10_bus_pkg::MASTER_NONE, "owner during power fail");
      end
      pwr_fail = 1'b0;
      @(negedge clk);
      check_grant(current_owner(), ks10_bus_pkg::MASTER_UBA, "owner after power fail");
      release_bus(ks10_bus_pkg::MASTER_UBA);

      // let the last data cycles drain
      repeat (4) @(negedge clk);
      if (expect_q.size() == 0)
      begin
         $display("PASS: all tests");
         $finish;
      end
      else
         report_error($sformatf("%0d expected data cycles never appeared", expect_q.size()));
   end

endmodule

//--- hdl/ks10_bus.sv
// top level: plain master ports mapped onto interfaces, arbiter and memory instances

`timescale 1ns/10ps

module ks10_bus
  #(
   parameter int MEM_WORDS = 1024
   )
  (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     pwr_fail,

   // console
   input  logic                     con_request,
   input  logic                     con_addr_cycle,
   input  logic                     con_data_cycle,
   input  logic                     con_io_cycle,
   input  ks10_bus_pkg::ks10_word_t con_data,
   output logic                     con_grant,

   // unibus adapter
   input  logic                     uba_request,
   input  logic                     uba_addr_cycle,
   input  logic                     uba_data_cycle,
   input  logic                     uba_io_cycle,
   input  ks10_bus_pkg::ks10_word_t uba_data,
   output logic                     uba_grant,

   // processor
   input  logic                     cpu_request,
   input  logic                     cpu_addr_cycle,
   input  logic                     cpu_data_cycle,
   input  logic                     cpu_io_cycle,
   input  ks10_bus_pkg::ks10_word_t cpu_data,
   output logic                     cpu_grant,

   // backplane as seen from outside
   output logic                     arb_addr_cycle,
   output logic                     arb_data_cycle,
   output logic                     arb_io_cycle,
   output logic                     arb_mem_busy,
   output ks10_bus_pkg::ks10_word_t arb_data
   );

   //////////////////////////////////////////////////
   // master ports
   //////////////////////////////////////////////////

   ks10_master_if con_bus ();
   ks10_master_if uba_bus ();
   ks10_master_if cpu_bus ();

   assign con_bus.request    = con_request;
   assign con_bus.addr_cycle = con_addr_cycle;
   assign con_bus.data_cycle = con_data_cycle;
   assign con_bus.io_cycle   = con_io_cycle;
   assign con_bus.data       = con_data;
   assign con_grant          = con_bus.grant;

   assign uba_bus.request    = uba_request;
   assign uba_bus.addr_cycle = uba_addr_cycle;
   assign uba_bus.data_cycle = uba_data_cycle;
   assign uba_bus.io_cycle   = uba_io_cycle;
   assign uba_bus.data       = uba_data;
   assign uba_grant          = uba_bus.grant;

   assign cpu_bus.request    = cpu_request;
   assign cpu_bus.addr_cycle = cpu_addr_cycle;
   assign cpu_bus.data_cycle = cpu_data_cycle;
   assign cpu_bus.io_cycle   = cpu_io_cycle;
   assign cpu_bus.data       = cpu_data;
   assign cpu_grant          = cpu_bus.grant;

   //////////////////////////////////////////////////
   // backplane
   //////////////////////////////////////////////////

   ks10_backplane_if bp ();

   assign arb_addr_cycle = bp.arb_addr_cycle;
   assign arb_data_cycle = bp.arb_data_cycle;
   assign arb_io_cycle   = bp.arb_io_cycle;
   assign arb_data       = bp.arb_data;
   // only the memory reports busy on this bus
   assign arb_mem_busy   = bp.mem_busy;

   //////////////////////////////////////////////////
   // devices
   //////////////////////////////////////////////////

   bus_arb u_arb
     (
      .clk      (clk),
      .rst      (rst),
      .pwr_fail (pwr_fail),
      .con      (con_bus),
      .uba      (uba_bus),
      .cpu      (cpu_bus),
      .bp       (bp)
      );

   mem_ctrl #(.MEM_WORDS (MEM_WORDS)) u_mem
     (
      .clk (clk),
      .rst (rst),
      .bp  (bp)
      );

endmodule

//--- hdl/mem_ctrl.sv
// memory controller: address cycle decode, read response pipeline and write store

`timescale 1ns/10ps

module mem_ctrl
  #(
   parameter int MEM_WORDS = 1024
   )
  (
   input logic           clk,
   input logic           rst,
   ks10_backplane_if.mem bp
   );

   //////////////////////////////////////////////////
   // declarations
   //////////////////////////////////////////////////

   // index width into the word array
   localparam int IDX_BITS = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

   // backplane word seen through the address view
   ks10_bus_pkg::ks10_addr_word_t addr_word;
   // physical address folded into the array
   logic [IDX_BITS-1:0]           addr_idx;

   // decoded requests this cycle
   logic                          mem_cycle;
   logic                          rd_start;
   logic                          wr_start;
   logic                          wr_done;

   // pipeline and pending state
   logic                          rd_pend;
   logic                          wr_pend;
   logic [IDX_BITS-1:0]           rd_idx;
   logic [IDX_BITS-1:0]           wr_idx;

   // storage
   ks10_bus_pkg::ks10_word_t      mem_array [0:MEM_WORDS-1];

   //////////////////////////////////////////////////
   // address cycle decode
   //////////////////////////////////////////////////

   assign addr_word.data = bp.arb_data;

   // addresses past the array wrap around
   assign addr_idx = IDX_BITS'(addr_word.addr.paddr % MEM_WORDS);

   // io cycles belong to nobody here
   assign mem_cycle = bp.arb_addr_cycle & ~bp.arb_io_cycle;

   assign rd_start = mem_cycle & addr_word.addr.flags[ks10_bus_pkg::FLAG_READ];
   assign wr_start = mem_cycle & addr_word.addr.flags[ks10_bus_pkg::FLAG_WRITE];

   // write data arrives on the data cycle after the address
   assign wr_done = wr_pend & bp.arb_data_cycle;

   //////////////////////////////////////////////////
   // control state
   //////////////////////////////////////////////////

   // read timing, relative to the backplane address cycle after edge k
   //   k+1  address sampled, rd_pend and busy set
   //   k+2  word driven with mem_data_cycle, busy still high
   //   k+3  response gone, busy drops
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rd_pend           <= 1'b0;
         wr_pend           <= 1'b0;
         bp.mem_data_cycle <= 1'b0;
         bp.mem_busy       <= 1'b0;
      end
      else
      begin
         rd_pend           <= rd_start;
         bp.mem_data_cycle <= rd_pend;
         bp.mem_busy       <= rd_start | rd_pend;

         // a fresh write address replaces any unfinished one
         if (wr_start)
            wr_pend <= 1'b1;
         else if (wr_done)
            wr_pend <= 1'b0;
      end
   end

   //////////////////////////////////////////////////
   // addresses, array and read data
   //////////////////////////////////////////////////

   // latch the decoded index for each kind of access
   always_ff @(posedge clk)
   begin
      if (rd_start)
         rd_idx <= addr_idx;
      if (wr_start)
         wr_idx <= addr_idx;
   end

   // second read stage fetches the word
   // mem_data holds its last value between reads
   always_ff @(posedge clk)
   begin
      if (rd_pend)
         bp.mem_data <= mem_array[rd_idx];
   end

   // word is stored on the edge that samples the data cycle
   always_ff @(posedge clk)
   begin
      if (wr_done)
         mem_array[wr_idx] <= bp.arb_data;
   end

endmodule

//--- hdl/bus_arb.sv
// bus arbiter: fixed priority grant state and registered relay onto the backplane

`timescale 1ns/10ps

module bus_arb
  (
   input logic           clk,
   input logic           rst,
   input logic           pwr_fail,
   ks10_master_if.arb    con,
   ks10_master_if.arb    uba,
   ks10_master_if.arb    cpu,
   ks10_backplane_if.arb bp
   );

   //////////////////////////////////////////////////
   // declarations
   //////////////////////////////////////////////////

   // current bus owner, the only grant state
   ks10_bus_pkg::ks10_master_t owner;
   // highest priority requester this cycle
   ks10_bus_pkg::ks10_master_t winner;

   // owner's lines, selected by the current owner
   logic                     owner_request;
   logic                     owner_addr_cycle;
   logic                     owner_data_cycle;
   logic                     owner_io_cycle;
   ks10_bus_pkg::ks10_word_t owner_data;

   //////////////////////////////////////////////////
   // priority pick
   //////////////////////////////////////////////////

   // console over unibus adapter over cpu
   always_comb
   begin
      if (con.request)
         winner = ks10_bus_pkg::MASTER_CON;
      else if (uba.request)
         winner = ks10_bus_pkg::MASTER_UBA;
      else if (cpu.request)
         winner = ks10_bus_pkg::MASTER_CPU;
      else
         winner = ks10_bus_pkg::MASTER_NONE;
   end

   //////////////////////////////////////////////////
   // grant state
   //////////////////////////////////////////////////

   // a new grant only from idle, so a release always leaves one idle cycle
   // pwr_fail blocks new grants but never cuts a running tenure
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         owner <= ks10_bus_pkg::MASTER_NONE;
      else if (owner == ks10_bus_pkg::MASTER_NONE)
      begin
         if (!pwr_fail)
            owner <= winner;
      end
      else if (!owner_request)
         // owner let go of the bus
         owner <= ks10_bus_pkg::MASTER_NONE;
   end

   // grant levels decoded from the owner register
   assign con.grant = (owner == ks10_bus_pkg::MASTER_CON);
   assign uba.grant = (owner == ks10_bus_pkg::MASTER_UBA);
   assign cpu.grant = (owner == ks10_bus_pkg::MASTER_CPU);

   //////////////////////////////////////////////////
   // owner mux
   //////////////////////////////////////////////////

   // lines of masters without a grant never get through this mux
   always_comb
   begin
      owner_request    = 1'b0;
      owner_addr_cycle = 1'b0;
      owner_data_cycle = 1'b0;
      owner_io_cycle   = 1'b0;
      owner_data       = con.data;
      case (owner)
         ks10_bus_pkg::MASTER_CON:
         begin
            owner_request    = con.request;
            owner_addr_cycle = con.addr_cycle;
            owner_data_cycle = con.data_cycle;
            owner_io_cycle   = con.io_cycle;
            owner_data       = con.data;
         end
         ks10_bus_pkg::MASTER_UBA:
         begin
            owner_request    = uba.request;
            owner_addr_cycle = uba.addr_cycle;
            owner_data_cycle = uba.data_cycle;
            owner_io_cycle   = uba.io_cycle;
            owner_data       = uba.data;
         end
         ks10_bus_pkg::MASTER_CPU:
         begin
            owner_request    = cpu.request;
            owner_addr_cycle = cpu.addr_cycle;
            owner_data_cycle = cpu.data_cycle;
            owner_io_cycle   = cpu.io_cycle;
            owner_data       = cpu.data;
         end
         default:
         begin
            // idle bus, strobes stay low
         end
      endcase
   end

   //////////////////////////////////////////////////
   // backplane relay
   //////////////////////////////////////////////////

   // strobes, one register stage
   // a memory response wins over the owner's lines
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         bp.arb_addr_cycle <= 1'b0;
         bp.arb_data_cycle <= 1'b0;
         bp.arb_io_cycle   <= 1'b0;
      end
      else if (bp.mem_data_cycle)
      begin
         bp.arb_addr_cycle <= 1'b0;
         bp.arb_data_cycle <= 1'b1;
         bp.arb_io_cycle   <= 1'b0;
      end
      else
      begin
         bp.arb_addr_cycle <= owner_addr_cycle;
         bp.arb_data_cycle <= owner_data_cycle;
         bp.arb_io_cycle   <= owner_io_cycle;
      end
   end

   // bus word follows the same selection as the strobes
   always_ff @(posedge clk)
   begin
      if (bp.mem_data_cycle)
         bp.arb_data <= bp.mem_data;
      else
         bp.arb_data <= owner_data;
   end

endmodule

//--- hdl/ks10_bus_if.sv
// master port interface and backplane interface with their modports

`timescale 1ns/10ps

//////////////////////////////////////////////////
// one bus master's lines into the arbiter
//////////////////////////////////////////////////

interface ks10_master_if;

   // level, held for the whole tenure
   logic                     request;
   // registered level from the arbiter
   logic                     grant;
   // cycle strobes, only honoured while granted
   logic                     addr_cycle;
   logic                     data_cycle;
   logic                     io_cycle;
   // address or data word for the current cycle
   ks10_bus_pkg::ks10_word_t data;

   // master side drives request, strobes and data
   modport master (output request, addr_cycle, data_cycle, io_cycle, data,
                   input  grant);

   // arbiter side sees the master and returns the grant
   modport arb (input  request, addr_cycle, data_cycle, io_cycle, data,
                output grant);

endinterface

//////////////////////////////////////////////////
// shared backplane as seen by every device
//////////////////////////////////////////////////

interface ks10_backplane_if;

   // relayed cycles, driven by the arbiter
   logic                     arb_addr_cycle;
   logic                     arb_data_cycle;
   logic                     arb_io_cycle;
   ks10_bus_pkg::ks10_word_t arb_data;

   // memory read response and busy flag
   logic                     mem_data_cycle;
   ks10_bus_pkg::ks10_word_t mem_data;
   logic                     mem_busy;

   modport arb (output arb_addr_cycle, arb_data_cycle, arb_io_cycle, arb_data,
                input  mem_data_cycle, mem_data, mem_busy);

   modport mem (input  arb_addr_cycle, arb_data_cycle, arb_io_cycle, arb_data,
                output mem_data_cycle, mem_data, mem_busy);

endinterface

//--- hdl/ks10_bus_pkg.sv
// bus word type, address/data word union, flag bit indices and bus owner enum

package ks10_bus_pkg;

   //////////////////////////////////////////////////
   // bus word
   //////////////////////////////////////////////////

   // one backplane word, numbered 0 (msb) to 35 (lsb) as on the KS10
   typedef logic [0:35] ks10_word_t;

   //////////////////////////////////////////////////
   // address cycle decode
   //////////////////////////////////////////////////

   // flag positions inside the 14-bit flags field of an address word
   // bit 0 requests a read
   localparam int FLAG_READ  = 0;
   // bit 1 requests a write
   localparam int FLAG_WRITE = 1;
   // bits 2..13 are reserved and ignored by the memory

   // the same 36 bits mean different things depending on the strobe:
   // during a data cycle the word is plain data, during an address
   // cycle it splits into flags and a 22-bit physical address
   typedef union packed
   {
      // data cycle view
      ks10_word_t data;

      // address cycle view
      struct packed
      {
         // read, write and reserved flags
         logic [0:13] flags;
         // physical address, bit 21 is the lsb
         logic [0:21] paddr;
      } addr;
   } ks10_addr_word_t;

   //////////////////////////////////////////////////
   // bus ownership
   //////////////////////////////////////////////////

   // which master currently holds the bus
   // none means the bus is idle and free for arbitration
   // fixed priority is con, then uba, then cpu
   typedef enum logic [1:0]
   {
      // no grant held
      MASTER_NONE = 2'd0,
      // console
      MASTER_CON  = 2'd1,
      // unibus adapter
      MASTER_UBA  = 2'd2,
      // processor
      MASTER_CPU  = 2'd3
   } ks10_master_t;

endpackage
